// File: rtl/mac_control.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module mac_control (
    input  logic clk_i,
    input  logic rstn,
    input  logic vld_i,
    output logic dec_en_o,
    output logic mul_en_o,
    output logic acc_en_o,
    output logic last_o,
    output logic norm_en_o,
    output logic pack_en_o,
    output logic vld_o
);

    localparam int CNT_W = $clog2(`BATCH_LEN);

    logic [2:0]       vld_q;
    logic             norm_q;
    logic             pack_q;
    logic [CNT_W-1:0] count_q;

    // decode, multiply, accumulate
    assign dec_en_o = vld_q[0];
    assign mul_en_o = vld_q[1];
    assign acc_en_o = vld_q[2];
    assign last_o   = vld_q[2] && (count_q == CNT_W'(`BATCH_LEN - 1));

    // only the batch-closing item continues past the quire
    assign norm_en_o = norm_q;
    assign pack_en_o = pack_q;

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_q   <= '0;
            norm_q  <= 1'b0;
            pack_q  <= 1'b0;
            vld_o   <= 1'b0;
            count_q <= '0;
        end else begin
            vld_q  <= {vld_q[1:0], vld_i};
            norm_q <= last_o;
            pack_q <= norm_q;
            vld_o  <= pack_q;
            if (acc_en_o)
                count_q <= last_o ? '0 : count_q + 1'b1;
        end
    end

    a_count_range: assert property (@(posedge clk_i) disable iff (!rstn)
        count_q < CNT_W'(`BATCH_LEN));

    // batches are at least nine strobes apart
    a_single_strobe: assert property (@(posedge clk_i) disable iff (!rstn)
        vld_o |=> !vld_o);

endmodule

// File: rtl/posit_cfg.svh
`ifndef POSIT_CFG_SVH
`define POSIT_CFG_SVH

// --------------------
// posit format
// --------------------
`define POSIT_WIDTH 8
`define POSIT_ES 2
// stored fraction bits with the shortest regime
`define FRAC_BITS (`POSIT_WIDTH - 3 - `POSIT_ES)
// scale of maxpos, minpos is the negative
`define MAX_SCALE ((`POSIT_WIDTH - 2) * (1 << `POSIT_ES))

// --------------------
// batch and quire
// --------------------
`define BATCH_LEN 9
// headroom for summing BATCH_LEN products
`define CARRY_BITS 4
// lsb of the quire is the weight of the smallest product lsb
`define QUIRE_FRAC (2 * `MAX_SCALE + 2 * `FRAC_BITS)
`define QUIRE_WIDTH (1 + `CARRY_BITS + 2 * `MAX_SCALE + 2 + `QUIRE_FRAC)

`endif

// File: rtl/posit_decoder.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_decoder import posit_pkg::*; (
    input  logic          clk_i,
    input  logic          rstn,
    input  logic          dec_en_i,
    input  posit_word_u   win_i,
    input  posit_word_u   din_i,
    output posit_fields_t w_fields_o,
    output posit_fields_t d_fields_o
);

    localparam logic [`POSIT_WIDTH-1:0] NAR_CODE = {1'b1, {(`POSIT_WIDTH-1){1'b0}}};

    posit_word_u w_code_q;
    posit_word_u d_code_q;

    // regime run, then exponent and fraction from what is left
    function automatic posit_fields_t decode_op(input posit_word_u code);
        posit_word_u             mag;
        logic [`POSIT_WIDTH-2:0] rem;
        logic                    run_done;
        int                      run;
        int                      k;
        int                      i;
        posit_fields_t           f;
        mag.raw = code.f.sign ? -code.raw : code.raw;
        run = 1;
        run_done = 1'b0;
        for (i = `POSIT_WIDTH - 3; i >= 0; i--) begin
            if (!run_done && mag.f.body[i] == mag.f.body[`POSIT_WIDTH-2])
                run++;
            else
                run_done = 1'b1;
        end
        k = mag.f.body[`POSIT_WIDTH-2] ? run - 1 : -run;
        // drop regime and terminator, missing bits read as zero
        rem = mag.f.body << (run + 1);
        f.sign = code.f.sign;
        f.zero = (code.raw == '0);
        f.scale = scale_t'(k * (1 << `POSIT_ES) + int'(rem[`POSIT_WIDTH-2 -: `POSIT_ES]));
        f.frac = {1'b1, rem[`POSIT_WIDTH-2-`POSIT_ES -: `FRAC_BITS]};
        return f;
    endfunction

    // input capture on the sampling edge
    always_ff @(posedge clk_i) begin
        w_code_q <= win_i;
        d_code_q <= din_i;
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            w_fields_o <= '0;
            d_fields_o <= '0;
        end else if (dec_en_i) begin
            w_fields_o <= decode_op(w_code_q);
            d_fields_o <= decode_op(d_code_q);
        end
    end

    // NaR is outside the supported input range
    a_no_nar: assert property (@(posedge clk_i) disable iff (!rstn)
        dec_en_i |-> (w_code_q.raw != NAR_CODE && d_code_q.raw != NAR_CODE));

endmodule

// File: rtl/posit_encoder.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_encoder import posit_pkg::*, quire_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn,
    input  logic        norm_en_i,
    input  logic        pack_en_i,
    input  quire_t      snap_i,
    output posit_word_u acc_o
);

    localparam int QW    = `QUIRE_WIDTH;
    localparam int MAG_W = QW - 1;
    localparam int BW    = `POSIT_WIDTH - 1;
    // fraction kept past the leading one, one more than can be stored
    localparam int NF    = `FRAC_BITS + 1;
    localparam int STR_W = 2 * `POSIT_WIDTH;
    localparam int PAD   = STR_W - 2 - `POSIT_ES - NF;
    localparam int SH_W  = $clog2(BW);

    quire_t             abs_c;
    logic [MAG_W-1:0]   mag_c;
    logic [MAG_W-1:0]   norm_c;
    int                 lead_c;
    int                 scale_c;

    logic               sign_n;
    logic               zero_n;
    logic               ovf_n;
    logic               udf_n;
    scale_t             scale_n;
    logic [NF-1:0]      frac_n;
    logic               sticky_n;

    scale_t             k_c;
    logic [SH_W-1:0]    sh_c;
    logic signed [STR_W-1:0] str_c;
    logic signed [STR_W-1:0] shifted_c;
    logic [BW-1:0]      body_c;
    logic               guard_c;
    logic               round_c;
    posit_word_u        res_c;

    // --------------------
    // normalize
    // --------------------
    always_comb begin
        abs_c = snap_i[QW-1] ? -snap_i : snap_i;
        mag_c = abs_c[MAG_W-1:0];
        lead_c = 0;
        for (int i = 0; i < MAG_W; i++) begin
            if (mag_c[i])
                lead_c = i;
        end
        // leading one moved to the top bit
        norm_c = mag_c << (MAG_W - 1 - lead_c);
        scale_c = lead_c - `QUIRE_FRAC;
    end

    always_ff @(posedge clk_i) begin
        if (norm_en_i) begin
            sign_n   <= snap_i[QW-1];
            zero_n   <= (mag_c == '0);
            ovf_n    <= (scale_c >= `MAX_SCALE);
            udf_n    <= (scale_c < -`MAX_SCALE);
            scale_n  <= scale_t'(scale_c);
            frac_n   <= norm_c[MAG_W-2 -: NF];
            sticky_n <= |norm_c[MAG_W-2-NF:0];
        end
    end

    // --------------------
    // pack and round
    // --------------------
    always_comb begin
        k_c = scale_n >>> `POSIT_ES;
        // k+1 ones for k >= 0, -k zeros otherwise
        sh_c = SH_W'(scale_n[$bits(scale_t)-1] ? ~k_c : k_c);
        str_c = {(scale_n[$bits(scale_t)-1] ? 2'b01 : 2'b10), scale_n[`POSIT_ES-1:0],
                 frac_n, {PAD{1'b0}}};
        shifted_c = str_c >>> sh_c;
        body_c  = shifted_c[STR_W-1 -: BW];
        guard_c = shifted_c[STR_W-1-BW];
        // nearest even, ties go to even lsb
        round_c = guard_c & (body_c[0] | (|shifted_c[STR_W-2-BW:0]) | sticky_n);
        res_c.f.sign = 1'b0;
        res_c.f.body = ovf_n ? '1 : body_c + BW'(round_c);
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn)
            acc_o <= '0;
        else if (pack_en_i)
            acc_o.raw <= (zero_n || udf_n) ? '0 : (sign_n ? -res_c.raw : res_c.raw);
    end

endmodule

// File: rtl/posit_mac_top.sv
`timescale 1ns/1ps

module posit_mac_top import posit_pkg::*, quire_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn,
    input  logic        vld_i,
    input  posit_word_u win_i,
    input  posit_word_u din_i,
    output posit_word_u acc_o,
    output logic        vld_o
);

    logic          dec_en;
    logic          mul_en;
    logic          acc_en;
    logic          last;
    logic          norm_en;
    logic          pack_en;
    posit_fields_t w_fields;
    posit_fields_t d_fields;
    product_t      prod;
    quire_t        snap;

    mac_control u_ctrl (
        .clk_i(clk_i), .rstn(rstn), .vld_i(vld_i),
        .dec_en_o(dec_en), .mul_en_o(mul_en), .acc_en_o(acc_en), .last_o(last),
        .norm_en_o(norm_en), .pack_en_o(pack_en), .vld_o(vld_o)
    );

    posit_decoder u_dec (
        .clk_i(clk_i), .rstn(rstn), .dec_en_i(dec_en),
        .win_i(win_i), .din_i(din_i),
        .w_fields_o(w_fields), .d_fields_o(d_fields)
    );

    posit_product u_mul (
        .clk_i(clk_i), .rstn(rstn), .mul_en_i(mul_en),
        .w_fields_i(w_fields), .d_fields_i(d_fields), .prod_o(prod)
    );

    quire_accumulator u_acc (
        .clk_i(clk_i), .rstn(rstn), .acc_en_i(acc_en), .last_i(last),
        .prod_i(prod), .snap_o(snap)
    );

    posit_encoder u_enc (
        .clk_i(clk_i), .rstn(rstn), .norm_en_i(norm_en), .pack_en_i(pack_en),
        .snap_i(snap), .acc_o(acc_o)
    );

endmodule

// File: rtl/posit_pkg.sv
`include "posit_cfg.svh"

package posit_pkg;

    // one posit code, seen raw or as sign plus body
    typedef union packed {
        logic [`POSIT_WIDTH-1:0] raw;
        struct packed {
            logic                    sign;
            logic [`POSIT_WIDTH-2:0] body;
        } f;
    } posit_word_u;

    // regime * 2^es + exponent
    // wide enough for product scales and quire scales
    typedef logic signed [6:0] scale_t;

    // decoded operand, frac carries the hidden one on top
    typedef struct packed {
        logic                  sign;
        logic                  zero;
        scale_t                scale;
        logic [`FRAC_BITS:0]   frac;
    } posit_fields_t;

endpackage

// File: rtl/posit_product.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_product import posit_pkg::*, quire_pkg::*; (
    input  logic          clk_i,
    input  logic          rstn,
    input  logic          mul_en_i,
    input  posit_fields_t w_fields_i,
    input  posit_fields_t d_fields_i,
    output product_t      prod_o
);

    logic [2*`FRAC_BITS+1:0] mant_c;
    scale_t                  scale_c;

    // 1.fff x 1.fff gives an exact 2.6 result
    assign mant_c = w_fields_i.frac * d_fields_i.frac;

    // operand scales stay within +-MAX_SCALE so the sum fits
    assign scale_c = w_fields_i.scale + d_fields_i.scale;

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            prod_o <= '0;
        end else if (mul_en_i) begin
            prod_o.sign  <= w_fields_i.sign ^ d_fields_i.sign;
            prod_o.zero  <= w_fields_i.zero | d_fields_i.zero;
            prod_o.scale <= scale_c;
            prod_o.mant  <= mant_c;
        end
    end

endmodule

// File: rtl/quire_accumulator.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module quire_accumulator import quire_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn,
    input  logic     acc_en_i,
    input  logic     last_i,
    input  product_t prod_i,
    output quire_t   snap_o
);

    localparam int QW = `QUIRE_WIDTH;
    localparam int MW = 2 * `FRAC_BITS + 2;
    // mant lsb weight is 2^(scale-6), quire lsb is 2^-QUIRE_FRAC
    localparam int ALIGN_OFS = `QUIRE_FRAC - 2 * `FRAC_BITS;

    logic [7:0] shift_c;
    quire_t     aligned_c;
    quire_t     term_c;
    quire_t     sum_c;
    quire_t     quire_q;

    // --------------------
    // align and add
    // --------------------
    assign shift_c   = 8'(int'(prod_i.scale) + ALIGN_OFS);
    assign aligned_c = prod_i.zero ? '0 : ({{(QW-MW){1'b0}}, prod_i.mant} << shift_c);
    assign term_c    = prod_i.sign ? -aligned_c : aligned_c;
    assign sum_c     = quire_q + term_c;

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn)
            quire_q <= '0;
        else if (acc_en_i)
            quire_q <= last_i ? '0 : sum_c;
    end

    // closing sum goes to the encoder
    always_ff @(posedge clk_i) begin
        if (acc_en_i && last_i)
            snap_o <= sum_c;
    end

    // carry bits must absorb a full batch
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!rstn)
        acc_en_i && !last_i && (quire_q[QW-1] == term_c[QW-1])
        |=> quire_q[QW-1] == $past(term_c[QW-1]));

endmodule

// File: rtl/quire_pkg.sv
`include "posit_cfg.svh"

package quire_pkg;

    import posit_pkg::*;

    // exact product, mant in 2.6 format
    typedef struct packed {
        logic                      sign;
        logic                      zero;
        scale_t                    scale;
        logic [2*`FRAC_BITS+1:0]   mant;
    } product_t;

    // two's complement fixed point, QUIRE_FRAC bits below the point
    typedef logic signed [`QUIRE_WIDTH-1:0] quire_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_posit_mac -f sim.f

./obj_dir/Vtb_posit_mac

// File: sim.f
+incdir+rtl
rtl/posit_pkg.sv
rtl/quire_pkg.sv
rtl/mac_control.sv
rtl/posit_decoder.sv
rtl/posit_product.sv
rtl/quire_accumulator.sv
rtl/posit_encoder.sv
rtl/posit_mac_top.sv
verification/tb_posit_mac.sv

// File: verification/tb_posit_mac.sv
`timescale 1ns/1ps
`include "posit_cfg.svh"

module tb_posit_mac import posit_pkg::*; ();

    localparam int N   = `BATCH_LEN;
    localparam int QF  = `QUIRE_FRAC;
    localparam int USE = 1 << `POSIT_ES;

    logic        clk_i;
    logic        rstn;
    logic        vld_i;
    posit_word_u win_i;
    posit_word_u din_i;
    posit_word_u acc_o;
    logic        vld_o;

    int          seed = 32'hb3c9;
    int          cycle;
    posit_word_u exp_q[$];
    int          due_q[$];
    posit_word_u last_code;

    posit_mac_top uut (
        .clk_i(clk_i), .rstn(rstn), .vld_i(vld_i),
        .win_i(win_i), .din_i(din_i), .acc_o(acc_o), .vld_o(vld_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic void decode_ref(input logic [7:0] code, output logic neg,
                                       output int mant, output int scale);
        logic [7:0] mag;
        logic       stop;
        int         run;
        int         idx;
        int         e;
        int         f;
        int         i;
        neg = code[7];
        mag = code[7] ? 8'(-code) : code;
        mant = 0;
        scale = 0;
        if (code == 8'h00)
            return;
        run = 0;
        stop = 1'b0;
        for (i = 6; i >= 0; i--) begin
            if (!stop && mag[i] == mag[6])
                run++;
            else
                stop = 1'b1;
        end
        // first bit after the regime terminator
        idx = 5 - run;
        e = 0;
        for (i = 0; i < `POSIT_ES; i++) begin
            e = 2 * e + ((idx >= 0) ? int'(mag[idx]) : 0);
            idx--;
        end
        f = 0;
        for (i = 0; i < `FRAC_BITS; i++) begin
            f = 2 * f + ((idx >= 0) ? int'(mag[idx]) : 0);
            idx--;
        end
        mant = (1 << `FRAC_BITS) + f;
        scale = (mag[6] ? run - 1 : -run) * USE + e;
    endfunction

    // posit bit string from a quire-scaled integer, rounded to nearest even
    function automatic logic [7:0] encode_ref(input logic signed [127:0] sum);
        logic [127:0] m;
        bit           str[$];
        logic [6:0]   body;
        logic         sticky;
        logic         up;
        logic [7:0]   code;
        int           p;
        int           s;
        int           k;
        int           e;
        int           i;
        if (sum == 0)
            return 8'h00;
        m = (sum < 0) ? -sum : sum;
        p = 0;
        for (i = 0; i < 128; i++) begin
            if (m[i])
                p = i;
        end
        s = p - QF;
        if (s < -`MAX_SCALE)
            return 8'h00;
        if (s >= `MAX_SCALE) begin
            code = 8'h7F;
        end else begin
            e = ((s % USE) + USE) % USE;
            k = (s - e) / USE;
            if (k >= 0) begin
                for (i = 0; i <= k; i++)
                    str.push_back(1'b1);
                str.push_back(1'b0);
            end else begin
                for (i = 0; i < -k; i++)
                    str.push_back(1'b0);
                str.push_back(1'b1);
            end
            str.push_back(e[1]);
            str.push_back(e[0]);
            for (i = p - 1; i >= 0; i--)
                str.push_back(m[i]);
            while (str.size() < 9)
                str.push_back(1'b0);
            body = '0;
            for (i = 0; i < 7; i++)
                body = {body[5:0], str[i]};
            sticky = 1'b0;
            for (i = 8; i < str.size(); i++)
                sticky = sticky | str[i];
            up = str[7] && (body[0] || sticky);
            code = {1'b0, body} + {7'b0, up};
        end
        return (sum < 0) ? 8'(-code) : code;
    endfunction

    function automatic logic [7:0] ref_batch(input logic [8*N-1:0] wv,
                                             input logic [8*N-1:0] dv);
        logic signed [127:0] sum;
        logic signed [127:0] term;
        logic                wn;
        logic                dn;
        int                  wm;
        int                  dm;
        int                  ws;
        int                  ds;
        int                  i;
        sum = '0;
        for (i = 0; i < N; i++) begin
            decode_ref(wv[8*i +: 8], wn, wm, ws);
            decode_ref(dv[8*i +: 8], dn, dm, ds);
            // product of two 1.fff values has six fraction bits
            term = 128'(wm * dm);
            term = term <<< (ws + ds + QF - 2 * `FRAC_BITS);
            sum = (wn ^ dn) ? sum - term : sum + term;
        end
        return encode_ref(sum);
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic fail_now();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_posit(input string name, input posit_word_u got,
                               input posit_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("[FAIL] %s: got %h, expected %h", name, got.raw, exp.raw);
            fail_now();
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            fail_now();
        end
    endtask

    // sample outputs away from the driving edge
    initial begin
        cycle = 0;
        last_code = '0;
        forever begin
            @(negedge clk_i);
            cycle++;
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                check_strobe("vld_o", vld_o, 1'b1);
                last_code = exp_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                check_strobe("vld_o", vld_o, 1'b0);
            end
            check_posit("acc_o", acc_o, last_code);
        end
    end

    // --------------------
    // stimulus
    // --------------------
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // narrow codes keep sums inside the posit range
    function automatic logic [7:0] random_code(input logic narrow);
        logic [7:0] c;
        if (narrow) begin
            c = 8'(32 + rand_below(64));
            if (rand_below(2) == 1)
                c = 8'(-c);
        end else begin
            c = 8'(rand_below(256));
            if (c == 8'h80)
                c = 8'h40;
        end
        return c;
    endfunction

    task automatic idle_cycle();
        @(posedge clk_i);
        vld_i <= 1'b0;
        win_i.raw <= random_code(1'b0);
        din_i.raw <= random_code(1'b0);
    endtask

    task automatic drive_batch(input logic [8*N-1:0] wv, input logic [8*N-1:0] dv,
                               input posit_word_u exp, input int gap_max);
        int i;
        int gap;
        for (i = 0; i < N; i++) begin
            @(posedge clk_i);
            vld_i <= 1'b1;
            win_i.raw <= wv[8*i +: 8];
            din_i.raw <= dv[8*i +: 8];
            if (i == N - 1) begin
                // sampled next edge, result five edges later
                exp_q.push_back(exp);
                due_q.push_back(cycle + 7);
            end else begin
                gap = rand_below(gap_max + 1);
                repeat (gap) idle_cycle();
            end
        end
    endtask

    task automatic random_batch(input logic narrow, input int gap_max);
        logic [8*N-1:0] wv;
        logic [8*N-1:0] dv;
        int             i;
        for (i = 0; i < N; i++) begin
            wv[8*i +: 8] = random_code(narrow);
            dv[8*i +: 8] = random_code(narrow);
        end
        drive_batch(wv, dv, ref_batch(wv, dv), gap_max);
    endtask

    task automatic directed_batch(input logic [8*N-1:0] wv, input logic [8*N-1:0] dv,
                                  input posit_word_u exp);
        check_posit("ref_batch", ref_batch(wv, dv), exp);
        drive_batch(wv, dv, exp, 1);
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 200) begin
            @(posedge clk_i);
            waited++;
        end
    endtask

    initial begin
        logic [8*N-1:0] wv;
        logic [8*N-1:0] dv;
        int             i;
        rstn = 1'b0;
        vld_i = 1'b0;
        win_i = '0;
        din_i = '0;
        repeat (2) @(posedge clk_i);
        rstn <= 1'b1;
        repeat (3) idle_cycle();

        // saturation, underflow
        directed_batch({N{8'h7F}}, {N{8'h7F}}, 8'h7F);
        directed_batch({N{8'h81}}, {N{8'h7F}}, 8'h81);
        directed_batch({N{8'h01}}, {N{8'h01}}, 8'h00);

        // pairs of equal and opposite products
        for (i = 0; i < N - 1; i += 2) begin
            wv[8*i +: 8] = random_code(1'b0);
            dv[8*i +: 8] = random_code(1'b0);
            wv[8*(i+1) +: 8] = 8'(-wv[8*i +: 8]);
            dv[8*(i+1) +: 8] = dv[8*i +: 8];
        end
        wv[8*(N-1) +: 8] = 8'h00;
        dv[8*(N-1) +: 8] = random_code(1'b0);
        directed_batch(wv, dv, 8'h00);

        // ties, 1.0625 stays at 0x40 and 1.1875 goes up to 0x42
        directed_batch({{(N-2){8'h00}}, 8'h20, 8'h40}, {N{8'h40}}, 8'h40);
        directed_batch({{(N-2){8'h00}}, 8'h20, 8'h41}, {N{8'h40}}, 8'h42);

        for (i = 0; i < 20; i++) begin
            random_batch(1'b1, 3);
            repeat (rand_below(5)) idle_cycle();
        end
        for (i = 0; i < 8; i++) begin
            random_batch(1'b0, 2);
            repeat (rand_below(3)) idle_cycle();
        end

        // back to back, no idle cycle between batches
        for (i = 0; i < 3; i++)
            random_batch(1'b1, 0);
        idle_cycle();

        wait_results();
        if (exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("timeout: %0d expected results never arrived", exp_q.size());
            fail_now();
        end
    end

endmodule
